//--- run.sh
#!/bin/sh
# Build and run the fetch testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module fetchTb -f src.f -o fetchSim \
  > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/fetchSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "RESULT: FAIL" sim.log; then
  exit 1
fi
exit 0

//--- src.f
+incdir+include
src/memCfgPkg.sv
src/fetchPkg.sv
src/syncRam.sv
src/instWindow.sv
src/instCache.sv
src/fetchCombine.sv
src/fetchTop.sv
testbench/fetchTb.sv

//--- src/fetchCombine.sv
`timescale 1ns/100ps
`default_nettype none

module fetchCombine (
  input wire SYSCLK,
  input wire arstN,
  input wire fetchReq,
  input wire [memCfgPkg::AddrWidth-1:0] fetchAddr,
  input wire winValid,
  input wire [memCfgPkg::DataWidth-1:0] winData,
  input wire cacheHit,
  input wire cacheMiss,
  input wire [memCfgPkg::DataWidth-1:0] cacheData,
  input wire refillValid,
  input wire [memCfgPkg::DataWidth-1:0] refillData,
  output logic fetchDone,
  output logic [memCfgPkg::DataWidth-1:0] fetchData,
  output fetchPkg::fetchSrcE fetchSrc,
  output logic missReq,
  output logic [memCfgPkg::AddrWidth-1:0] missAddr,
  output logic refillWe,
  output logic [memCfgPkg::AddrWidth-1:0] refillAddr,
  output logic busy
);

  import memCfgPkg::*;
  import fetchPkg::*;

  combStateE state;
  logic [AddrWidth-1:0] reqAddr;

  always_ff @(posedge SYSCLK or negedge arstN) begin
    if (!arstN) begin
      state <= stIdle;
      fetchDone <= 1'b0;
    end else begin
      fetchDone <= 1'b0;
      case (state)
        stIdle: begin
          if (fetchReq) begin
            state <= stLookup;
          end
        end
        stLookup: begin
          if (winValid || cacheHit) begin
            fetchDone <= 1'b1;
            state <= stIdle;
          end else if (cacheMiss) begin
            state <= stWaitRefill;
          end else begin
            state <= stIdle;
          end
        end
        stWaitRefill: begin
          if (refillValid) begin
            fetchDone <= 1'b1;
            state <= stIdle;
          end
        end
        default: state <= stIdle;
      endcase
    end
  end

  always_ff @(posedge SYSCLK) begin
    if (state == stIdle && fetchReq) begin
      reqAddr <= fetchAddr;
    end
    if (state == stLookup && winValid) begin
      fetchData <= winData; // Window wins over the cache.
      fetchSrc <= srcWindow;
    end else if (state == stLookup && cacheHit) begin
      fetchData <= cacheData;
      fetchSrc <= srcCache;
    end else if (refillWe) begin
      fetchData <= refillData;
      fetchSrc <= srcRefill;
    end
  end

  assign missReq = state == stWaitRefill;
  assign missAddr = reqAddr;
  assign refillWe = missReq && refillValid; // Cache line written on the same edge.
  assign refillAddr = reqAddr;
  assign busy = (state != stIdle) || fetchDone;

  assert property (@(posedge SYSCLK) disable iff (!arstN) fetchReq |-> !busy);

endmodule

`default_nettype wire

//--- src/fetchPkg.sv
`default_nettype none

package fetchPkg;

  // Part that delivered a fetch result.
  typedef enum logic [1:0] {
    srcNone = 2'd0,
    srcWindow = 2'd1,
    srcCache = 2'd2,
    srcRefill = 2'd3
  } fetchSrcE;

  // Combiner FSM states.
  typedef enum logic [1:0] {
    stIdle = 2'd0,
    stLookup = 2'd1, // RAM results arrive.
    stWaitRefill = 2'd2
  } combStateE;

endpackage

`default_nettype wire

//--- src/fetchTop.sv
`timescale 1ns/100ps
`default_nettype none

module fetchTop #(
  parameter int CacheIndexBits = 6,
  parameter int WindowIndexBits = 8
) (
  input wire SYSCLK,
  input wire arstN,
  input wire fetchReq,
  input wire [memCfgPkg::AddrWidth-1:0] fetchAddr,
  input wire [memCfgPkg::AddrWidth-1:0] iwBase,
  input wire [memCfgPkg::AddrWidth-1:0] iwTop,
  input wire loadWe,
  input wire [memCfgPkg::AddrWidth-1:0] loadAddr,
  input wire [memCfgPkg::DataWidth-1:0] loadData,
  input wire flush,
  input wire refillValid,
  input wire [memCfgPkg::DataWidth-1:0] refillData,
  output logic fetchDone,
  output logic [memCfgPkg::DataWidth-1:0] fetchData,
  output fetchPkg::fetchSrcE fetchSrc,
  output logic missReq,
  output logic [memCfgPkg::AddrWidth-1:0] missAddr,
  output logic busy
);

  import memCfgPkg::*;

  logic winValid;
  logic [DataWidth-1:0] winData;
  logic cacheHit;
  logic cacheMiss;
  logic [DataWidth-1:0] cacheData;
  logic refillWe;
  logic [AddrWidth-1:0] refillAddr;

  instWindow #(
    .WindowIndexBits(WindowIndexBits)
  ) window (
    .SYSCLK(SYSCLK),
    .arstN(arstN),
    .fetchReq(fetchReq),
    .fetchAddr(fetchAddr),
    .iwBase(iwBase),
    .iwTop(iwTop),
    .loadWe(loadWe),
    .loadAddr(loadAddr),
    .loadData(loadData),
    .winValid(winValid),
    .winData(winData)
  );

  instCache #(
    .CacheIndexBits(CacheIndexBits)
  ) cache (
    .SYSCLK(SYSCLK),
    .arstN(arstN),
    .fetchReq(fetchReq),
    .fetchAddr(fetchAddr),
    .flush(flush),
    .refillWe(refillWe),
    .refillAddr(refillAddr),
    .refillData(refillData),
    .cacheHit(cacheHit),
    .cacheMiss(cacheMiss),
    .cacheData(cacheData)
  );

  fetchCombine combiner (
    .SYSCLK(SYSCLK),
    .arstN(arstN),
    .fetchReq(fetchReq),
    .fetchAddr(fetchAddr),
    .winValid(winValid),
    .winData(winData),
    .cacheHit(cacheHit),
    .cacheMiss(cacheMiss),
    .cacheData(cacheData),
    .refillValid(refillValid),
    .refillData(refillData),
    .fetchDone(fetchDone),
    .fetchData(fetchData),
    .fetchSrc(fetchSrc),
    .missReq(missReq),
    .missAddr(missAddr),
    .refillWe(refillWe),
    .refillAddr(refillAddr),
    .busy(busy)
  );

endmodule

`default_nettype wire

//--- src/instCache.sv
`timescale 1ns/100ps
`default_nettype none

module instCache #(
  parameter int CacheIndexBits = 6
) (
  input wire SYSCLK,
  input wire arstN,
  input wire fetchReq,
  input wire [memCfgPkg::AddrWidth-1:0] fetchAddr,
  input wire flush,
  input wire refillWe,
  input wire [memCfgPkg::AddrWidth-1:0] refillAddr,
  input wire [memCfgPkg::DataWidth-1:0] refillData,
  output logic cacheHit,
  output logic cacheMiss,
  output logic [memCfgPkg::DataWidth-1:0] cacheData
);

  import memCfgPkg::*;
  import fetchPkg::*;

  localparam int Lines = 1 << CacheIndexBits;
  localparam int TagBits = AddrWidth - CacheIndexBits - ByteOffBits;

  logic [Lines-1:0] validQ;
  logic [CacheIndexBits-1:0] fetchIndex;
  logic [CacheIndexBits-1:0] refillIndex;
  logic [CacheIndexBits-1:0] ramIndex;
  logic [CacheIndexBits-1:0] reqIndex;
  logic [TagBits-1:0] reqTag;
  logic [TagBits-1:0] tagRd;
  logic ramCsN;
  logic tagMatch;
  fetchSrcE lookSrc;

  assign fetchIndex = fetchAddr[CacheIndexBits+ByteOffBits-1:ByteOffBits];
  assign refillIndex = refillAddr[CacheIndexBits+ByteOffBits-1:ByteOffBits];
  assign ramIndex = refillWe ? refillIndex : fetchIndex;
  assign ramCsN = !(fetchReq || refillWe);

  syncRam #(
    .Depth(Lines),
    .Width(TagBits)
  ) tagRam (
    .SYSCLK(SYSCLK),
    .addr(ramIndex),
    .we(refillWe),
    .re(fetchReq),
    .csN(ramCsN),
    .dataIn(refillAddr[AddrWidth-1:AddrWidth-TagBits]),
    .dataOut(tagRd)
  );

  syncRam #(
    .Depth(Lines),
    .Width(DataWidth)
  ) dataRam (
    .SYSCLK(SYSCLK),
    .addr(ramIndex),
    .we(refillWe),
    .re(fetchReq),
    .csN(ramCsN),
    .dataIn(refillData),
    .dataOut(cacheData)
  );

  always_ff @(posedge SYSCLK or negedge arstN) begin
    if (!arstN) begin
      validQ <= '0;
      lookSrc <= srcNone;
    end else begin
      lookSrc <= fetchReq ? srcCache : srcNone;
      if (flush) begin
        validQ <= '0;
      end else if (refillWe) begin
        validQ[refillIndex] <= 1'b1;
      end
    end
  end

  always_ff @(posedge SYSCLK) begin
    if (fetchReq) begin
      reqIndex <= fetchIndex;
      reqTag <= fetchAddr[AddrWidth-1:AddrWidth-TagBits];
    end
  end

  assign tagMatch = validQ[reqIndex] && (tagRd == reqTag);
  assign cacheHit = (lookSrc == srcCache) && tagMatch;
  assign cacheMiss = (lookSrc == srcCache) && !tagMatch;

  // Flush comes only while no lookup or refill is in flight.
  assert property (@(posedge SYSCLK) disable iff (!arstN)
    flush |-> (lookSrc != srcCache) && !refillWe);

endmodule

`default_nettype wire

//--- src/instWindow.sv
`timescale 1ns/100ps
`default_nettype none

module instWindow #(
  parameter int WindowIndexBits = 8
) (
  input wire SYSCLK,
  input wire arstN,
  input wire fetchReq,
  input wire [memCfgPkg::AddrWidth-1:0] fetchAddr,
  input wire [memCfgPkg::AddrWidth-1:0] iwBase,
  input wire [memCfgPkg::AddrWidth-1:0] iwTop,
  input wire loadWe,
  input wire [memCfgPkg::AddrWidth-1:0] loadAddr,
  input wire [memCfgPkg::DataWidth-1:0] loadData,
  output logic winValid,
  output logic [memCfgPkg::DataWidth-1:0] winData
);

  import memCfgPkg::*;
  import fetchPkg::*;

  localparam int Depth = 1 << WindowIndexBits;
  localparam int WordBits = AddrWidth - ByteOffBits;

  logic [WordBits-1:0] fetchOff;
  logic [WordBits-1:0] loadOff;
  logic fetchIn;
  logic loadIn;
  logic ramWe;
  logic [WindowIndexBits-1:0] ramAddr;
  fetchSrcE rdSrc;

  // Top is exclusive and the offset must fit the RAM.
  function automatic logic inWindow(
    input logic [AddrWidth-1:0] addr,
    input logic [WordBits-1:0] off,
    input logic [AddrWidth-1:0] base,
    input logic [AddrWidth-1:0] top
  );
    logic aboveBase;
    logic belowTop;
    aboveBase = addr[AddrWidth-1:ByteOffBits] >= base[AddrWidth-1:ByteOffBits];
    belowTop = addr[AddrWidth-1:ByteOffBits] < top[AddrWidth-1:ByteOffBits];
    return aboveBase && belowTop && ((off >> WindowIndexBits) == '0);
  endfunction

  assign fetchOff = fetchAddr[AddrWidth-1:ByteOffBits] - iwBase[AddrWidth-1:ByteOffBits];
  assign loadOff = loadAddr[AddrWidth-1:ByteOffBits] - iwBase[AddrWidth-1:ByteOffBits];
  assign fetchIn = inWindow(fetchAddr, fetchOff, iwBase, iwTop);
  assign loadIn = inWindow(loadAddr, loadOff, iwBase, iwTop);

  assign ramWe = loadWe && loadIn; // Out of range loads are dropped.
  assign ramAddr = loadWe ? loadOff[WindowIndexBits-1:0] : fetchOff[WindowIndexBits-1:0];

  syncRam #(
    .Depth(Depth),
    .Width(DataWidth)
  ) winRam (
    .SYSCLK(SYSCLK),
    .addr(ramAddr),
    .we(ramWe),
    .re(fetchReq),
    .csN(!(ramWe || fetchReq)),
    .dataIn(loadData),
    .dataOut(winData)
  );

  always_ff @(posedge SYSCLK or negedge arstN) begin
    if (!arstN) begin
      rdSrc <= srcNone;
    end else begin
      rdSrc <= (fetchReq && fetchIn) ? srcWindow : srcNone; // Tags the RAM read slot.
    end
  end

  assign winValid = rdSrc == srcWindow;

  // Loads and fetches share the single RAM port.
  assert property (@(posedge SYSCLK) disable iff (!arstN) !(loadWe && fetchReq));

endmodule

`default_nettype wire

//--- src/memCfgPkg.sv
`default_nettype none

package memCfgPkg;

  localparam int AddrWidth = 32; // Byte address width.
  localparam int DataWidth = 32; // Instruction word width.

  // Byte lane bits below a word, ignored on every fetch path.
  localparam int ByteOffBits = 2;

endpackage

`default_nettype wire

//--- src/syncRam.sv
`timescale 1ns/100ps
`default_nettype none

module syncRam #(
  parameter int Depth = 64,
  parameter int Width = 32
) (
  input wire SYSCLK,
  input wire [$clog2(Depth)-1:0] addr,
  input wire we,
  input wire re,
  input wire csN,
  input wire [Width-1:0] dataIn,
  output logic [Width-1:0] dataOut
);

  logic [Width-1:0] mem [Depth];

  always_ff @(posedge SYSCLK) begin
    if (!csN && we) begin
      mem[addr] <= dataIn;
    end
    if (!csN && re) begin
      dataOut <= mem[addr]; // Holds the last word otherwise.
    end
  end

endmodule

`default_nettype wire

//--- testbench/fetchPatterns.txt
# R base top | L addr data | F addr expData expSrc | W refillData | X flush | T testName
# Values in hex. expSrc: 1 window, 2 cache, 3 refill (next W line supplies the word).
R 00001000 00001400
L 00001000 a5a50001
L 000013fc a5a500ff
F 00001000 a5a50001 1
F 000013fc a5a500ff 1
T windowFetch
F 00008010 c0de0010 3
W c0de0010
T missRefill
F 00008010 c0de0010 2
F 00009010 c0de9010 3
W c0de9010
F 00009010 c0de9010 2
F 00008010 c0de8010 3
W c0de8010
T cacheHit
F 00009010 c0de9011 3
W c0de9011
R 00009000 00009400
L 00009010 77770010
F 00009010 77770010 1
R 00001000 00001400
T windowPriority
F 00009010 c0de9011 2
X
F 00009010 0badf00d 3
W 0badf00d
F 00009010 0badf00d 2
T flush
L 0000a000 deadbeef
F 0000a000 1234abcd 3
W 1234abcd
L 00001400 deadbeef
F 00001400 5678ef01 3
W 5678ef01
T outOfRangeLoad

//--- include/tbTasks.svh
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

int errors = 0;
int checks = 0;
bit timedOut = 1'b0;

task automatic checkValue(input logic [31:0] got, input logic [31:0] exp, input string msg);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("MISMATCH at %0t: %s, got %h, expected %h", $time, msg, got, exp);
  end
endtask

// Cycles counts falling edges up to fetchDone and is zero after a timeout.
task automatic waitDone(input int limit, output int cycles, output bit sawMiss);
  cycles = 0;
  sawMiss = 1'b0;
  while (cycles < limit) begin
    @(negedge SYSCLK);
    cycles++;
    sawMiss |= missReq;
    checkValue(32'(busy), 32'd1, "busy while a fetch is open");
    if (fetchDone) return;
  end
  errors++;
  timedOut = 1'b1;
  cycles = 0;
  $display("Timed out after %0d cycles waiting for fetchDone at %0t", limit, $time);
endtask

`endif

//--- testbench/fetchTb.sv
`timescale 1ns/100ps
`default_nettype none

module fetchTb;

  import memCfgPkg::*;
  import fetchPkg::*;

  localparam int DoneLimit = 20;
  localparam int WinBits = 8;
  localparam int WinWords = 1 << WinBits;

  logic SYSCLK = 1'b0;
  logic arstN;
  logic fetchReq;
  logic [AddrWidth-1:0] fetchAddr;
  logic [AddrWidth-1:0] iwBase;
  logic [AddrWidth-1:0] iwTop;
  logic loadWe;
  logic [AddrWidth-1:0] loadAddr;
  logic [DataWidth-1:0] loadData;
  logic flush;
  logic refillValid;
  logic [DataWidth-1:0] refillData;
  logic fetchDone;
  logic [DataWidth-1:0] fetchData;
  fetchSrcE fetchSrc;
  logic missReq;
  logic [AddrWidth-1:0] missAddr;
  logic busy;

  int fd;
  int n;
  int testsRun;
  int testErrStart;
  string line;
  bit pendActive;
  logic [DataWidth-1:0] pendData;
  logic [DataWidth-1:0] winModel [WinWords]; // Expected word per window RAM slot.
  bit winKnown [WinWords];

  `include "tbTasks.svh"

  fetchTop #(
    .CacheIndexBits(6),
    .WindowIndexBits(WinBits)
  ) DUT (
    .SYSCLK(SYSCLK),
    .arstN(arstN),
    .fetchReq(fetchReq),
    .fetchAddr(fetchAddr),
    .iwBase(iwBase),
    .iwTop(iwTop),
    .loadWe(loadWe),
    .loadAddr(loadAddr),
    .loadData(loadData),
    .flush(flush),
    .refillValid(refillValid),
    .refillData(refillData),
    .fetchDone(fetchDone),
    .fetchData(fetchData),
    .fetchSrc(fetchSrc),
    .missReq(missReq),
    .missAddr(missAddr),
    .busy(busy)
  );

  always #2 SYSCLK = ~SYSCLK; // 4 ns period.

  function automatic string trimEol(input string text);
    string s;
    s = text;
    while (s.len() > 0 &&
        (s.getc(s.len() - 1) == 8'h0a || s.getc(s.len() - 1) == 8'h0d)) begin
      s = s.substr(0, s.len() - 2);
    end
    return s;
  endfunction

  task automatic endTest(input string name);
    testsRun++;
    $display("Test %s finished with %0d errors", name, errors - testErrStart);
    testErrStart = errors;
  endtask

  task automatic waitMiss(output int cycles);
    cycles = 0;
    while (cycles < DoneLimit) begin
      @(negedge SYSCLK);
      cycles++;
      checkValue(32'(fetchDone), 32'd0, "fetchDone before refill");
      if (missReq) return;
    end
    errors++;
    timedOut = 1'b1;
    cycles = 0;
    $display("Timed out after %0d cycles waiting for missReq at %0t", DoneLimit, $time);
  endtask

  task automatic fetchWord(input logic [31:0] addr, input logic [31:0] expData,
      input logic [31:0] expSrc);
    int cycles;
    bit sawMiss;
    @(negedge SYSCLK);
    checkValue(32'(busy), 32'd0, "busy before request");
    @(posedge SYSCLK);
    fetchReq <= 1'b1;
    fetchAddr <= addr;
    @(posedge SYSCLK);
    fetchReq <= 1'b0;
    if (expSrc == 32'(srcRefill)) begin
      waitMiss(cycles);
      checkValue(32'(cycles), 32'd2, "missReq latency");
      checkValue(missAddr, addr, "missAddr");
      pendActive = 1'b1; // Result arrives with the next refill line.
      pendData = expData;
    end else begin
      waitDone(DoneLimit, cycles, sawMiss);
      checkValue(32'(cycles), 32'd2, "hit latency");
      checkValue(32'(sawMiss), 32'd0, "missReq during a hit");
      checkValue(fetchData, expData, "fetchData on a hit");
      checkValue(32'(fetchSrc), expSrc, "fetchSrc on a hit");
    end
  endtask

  // Fetches every window word the model holds, at its address in the current range.
  task automatic checkWindow();
    logic [AddrWidth-1:0] addr;
    logic [WinBits-1:0] idx;
    for (int i = 0; i < WinWords; i++) begin
      idx = WinBits'(i);
      addr = iwBase + AddrWidth'({idx, 2'b00});
      if (winKnown[idx] && addr < iwTop) begin
        fetchWord(addr, winModel[idx], 32'(srcWindow));
      end
    end
  endtask

  task automatic refillWord(input logic [31:0] data);
    int cycles;
    bit sawMiss;
    if (!pendActive) begin
      errors++;
      $display("Refill line at %0t has no miss waiting for it", $time);
      return;
    end
    @(negedge SYSCLK);
    checkValue(32'(missReq), 32'd1, "missReq held until refill");
    @(posedge SYSCLK);
    refillValid <= 1'b1;
    refillData <= data;
    @(posedge SYSCLK);
    refillValid <= 1'b0;
    pendActive = 1'b0;
    waitDone(DoneLimit, cycles, sawMiss);
    checkValue(32'(cycles), 32'd1, "refill to fetchDone latency");
    checkValue(fetchData, pendData, "fetchData after refill");
    checkValue(32'(fetchSrc), 32'(srcRefill), "fetchSrc after refill");
    checkValue(32'(missReq), 32'd0, "missReq after fetchDone");
  endtask

  task automatic runLine(input string text);
    byte opc;
    string rest;
    logic [31:0] argA;
    logic [31:0] argB;
    logic [31:0] argC;
    logic [31:0] wordOff;
    opc = text.getc(0);
    rest = text.substr(1, text.len() - 1);
    void'($sscanf(rest, "%h %h %h", argA, argB, argC));
    case (opc)
      "R": begin
        @(posedge SYSCLK);
        iwBase <= argA;
        iwTop <= argB;
      end
      "L": begin
        @(posedge SYSCLK);
        loadWe <= 1'b1;
        loadAddr <= argA;
        loadData <= argB;
        @(posedge SYSCLK);
        loadWe <= 1'b0;
        wordOff = (argA - iwBase) >> 2;
        if (argA >= iwBase && argA < iwTop && wordOff < WinWords) begin
          winModel[wordOff[WinBits-1:0]] = argB;
          winKnown[wordOff[WinBits-1:0]] = 1'b1;
        end else begin
          checkWindow(); // A dropped load leaves the window as it was.
        end
      end
      "F": fetchWord(argA, argB, argC);
      "W": refillWord(argA);
      "X": begin
        @(posedge SYSCLK);
        flush <= 1'b1;
        @(posedge SYSCLK);
        flush <= 1'b0;
      end
      "T": endTest(text.substr(2, text.len() - 1));
      default: begin
        errors++;
        $display("Unknown operation in pattern line: %s", text);
      end
    endcase
  endtask

  initial begin
    void'($urandom(32'h37a3));
    arstN = 1'b0;
    fetchReq = 1'b0;
    fetchAddr = '0;
    iwBase = '0;
    iwTop = '0;
    loadWe = 1'b0;
    loadAddr = '0;
    loadData = '0;
    flush = 1'b0;
    refillValid = 1'b0;
    refillData = '0;
    pendActive = 1'b0;
    pendData = '0;
    testsRun = 0;
    testErrStart = 0;
    repeat (3) @(posedge SYSCLK);
    arstN <= 1'b1;
    @(negedge SYSCLK);
    checkValue(32'(fetchDone), 32'd0, "fetchDone after reset");
    checkValue(32'(missReq), 32'd0, "missReq after reset");
    checkValue(32'(busy), 32'd0, "busy after reset");
    endTest("resetStatus");
    fd = $fopen("testbench/fetchPatterns.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Could not open the pattern file testbench/fetchPatterns.txt");
    end else begin
      while (!$feof(fd) && !timedOut) begin
        n = $fgets(line, fd);
        line = trimEol(line);
        if (n == 0 || line.len() == 0 || line.getc(0) == "#") continue;
        runLine(line);
        repeat ($urandom % 4) @(posedge SYSCLK); // Idle gap.
      end
      $fclose(fd);
    end
    $display("Tests run: %0d, checks: %0d, errors: %0d", testsRun, checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
